// File: all.f
portalPkg.sv
portalFifo.sv
burstSplitter.sv
portalReadPath.sv
portalWritePath.sv
portalTop.sv
tbClock.sv
portalTb.sv

// File: burstSplitter.sv
`timescale 1ns/1ps
`default_nettype none

module burstSplitter #(
  parameter int IdWidth = portalPkg::IdWidth,
  parameter int LenWidth = portalPkg::LenWidth,
  parameter int FifoDepth = 2
) (
  input  logic CLK,
  input  logic nRST,
  input  portalPkg::portalAddrU addr,
  input  logic [IdWidth-1:0] id,
  input  logic [LenWidth-1:0] len,
  input  logic valid,
  output logic ready,
  output logic beatValid,
  output logic [portalPkg::OffsetWidth-1:0] beatOffset,
  output logic [IdWidth-1:0] beatId,
  output logic beatSel,
  output logic beatCtrl,
  output logic beatLast,
  input  logic beatTake
);
  import portalPkg::*;

  localparam int ReqWidth = 2 + OffsetWidth + IdWidth + LenWidth;

  logic [ReqWidth-1:0] reqIn;
  logic [ReqWidth-1:0] reqOut;
  logic reqEmpty;
  logic reqSel;
  logic reqCtrl;
  logic [OffsetWidth-1:0] reqOffset;
  logic [IdWidth-1:0] reqId;
  logic [LenWidth-1:0] reqLen;
  logic first;
  logic [LenWidth:0] remain;
  logic [LenWidth:0] curRemain;
  logic [OffsetWidth-1:0] nextOffset;
  logic [OffsetWidth-1:0] curOffset;
  logic take;

  // Select and control flag are decoded once, then travel with every beat
  assign reqIn = {addr.fields.sel, addr.fields.chan == '0, addr.fields.offset, id, len};
  assign ready = reqEmpty;  // One burst at a time

  portalFifo #(.Width(ReqWidth), .FifoDepth(FifoDepth)) reqFifo (
    .CLK(CLK),
    .nRST(nRST),
    .enq(valid && ready),
    .din(reqIn),
    .deq(take && beatLast),
    .dout(reqOut),
    .full(),
    .empty(reqEmpty)
  );

  assign {reqSel, reqCtrl, reqOffset, reqId, reqLen} = reqOut;

  assign curRemain = first ? {1'b0, reqLen} + 1'b1 : remain;
  assign curOffset = first ? reqOffset : nextOffset;
  assign take = beatValid && beatTake;

  assign beatValid = !reqEmpty;
  assign beatOffset = curOffset;
  assign beatId = reqId;
  assign beatSel = reqSel;
  assign beatCtrl = reqCtrl;
  assign beatLast = curRemain == 1;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      first <= 1'b1;
      remain <= '0;
    end else if (take) begin
      first <= beatLast;
      remain <= curRemain - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (take)
      nextOffset <= curOffset + OffsetWidth'(4);  // Wraps in five bits
  end

endmodule

`default_nettype wire

// File: portalFifo.sv
`timescale 1ns/1ps
`default_nettype none

module portalFifo #(
  parameter int Width = 32,
  parameter int FifoDepth = 2
) (
  input  logic CLK,
  input  logic nRST,
  input  logic enq,
  input  logic [Width-1:0] din,
  input  logic deq,
  output logic [Width-1:0] dout,
  output logic full,
  output logic empty
);
  localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CountWidth = $clog2(FifoDepth + 1);

  logic [Width-1:0] mem [FifoDepth];
  logic [PtrWidth-1:0] wrPtr;
  logic [PtrWidth-1:0] rdPtr;
  logic [CountWidth-1:0] count;
  logic doEnq;
  logic doDeq;

  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] p);
    return (p == PtrWidth'(FifoDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full = count == CountWidth'(FifoDepth);
  assign empty = count == '0;
  assign doEnq = enq && !full;     // Guarded, overflow dropped
  assign doDeq = deq && !empty;
  assign dout = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (doEnq)
      mem[wrPtr] <= din;
  end

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doEnq)
        wrPtr <= nextPtr(wrPtr);
      if (doDeq)
        rdPtr <= nextPtr(rdPtr);
      if (doEnq && !doDeq)
        count <= count + 1'b1;
      else if (doDeq && !doEnq)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: portalPkg.sv
`default_nettype none

package portalPkg;

  localparam int DataWidth = 32;
  localparam int IdWidth = 6;
  localparam int LenWidth = 4;     // Beats minus one
  localparam int OffsetWidth = 5;

  // Bus address as seen by the portal
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [18:0] pad;
      logic sel;                     // Portal select, bit 12
      logic [6:0] chan;              // Channel 0 is the control page
      logic [OffsetWidth-1:0] offset;
    } fields;
  } portalAddrU;

  // Control page offsets
  localparam logic [OffsetWidth-1:0] IntrEnableOffset = 5'h04;
  localparam logic [OffsetWidth-1:0] NumTilesOffset = 5'h08;
  localparam logic [OffsetWidth-1:0] IndStatusOffset = 5'h0C;
  localparam logic [OffsetWidth-1:0] PortalIdOffset = 5'h10;
  localparam logic [OffsetWidth-1:0] NumPortalsOffset = 5'h14;

  localparam int NumTiles = 1;
  localparam int NumPortals = 2;
  localparam int PortalIdLow = 5;
  localparam int PortalIdHigh = 6;

  localparam logic [DataWidth-1:0] CtrlDefaultWord = 32'h005A05A0;

endpackage

`default_nettype wire

// File: portalReadPath.sv
`timescale 1ns/1ps
`default_nettype none

module portalReadPath #(
  parameter int DataWidth = portalPkg::DataWidth,
  parameter int IdWidth = portalPkg::IdWidth,
  parameter int FifoDepth = 2
) (
  input  logic CLK,
  input  logic nRST,
  input  logic beatValid,
  input  logic [portalPkg::OffsetWidth-1:0] beatOffset,
  input  logic [IdWidth-1:0] beatId,
  input  logic beatSel,
  input  logic beatCtrl,
  input  logic beatLast,
  output logic beatTake,
  input  logic indValid,
  input  logic [DataWidth-1:0] indData,
  output logic indTake,
  input  logic reqReady,
  output logic [DataWidth-1:0] rData,
  output logic [IdWidth-1:0] rId,
  output logic rLast,
  output logic rValid,
  input  logic rReady
);
  import portalPkg::*;

  localparam int EntryWidth = 1 + IdWidth + DataWidth;

  logic take;
  logic [DataWidth-1:0] ctrlWord;
  logic [DataWidth-1:0] userWord;
  logic [DataWidth-1:0] readWord;
  logic [EntryWidth-1:0] dataOut;
  logic dataFull;
  logic dataEmpty;

  assign beatTake = !dataFull;
  assign take = beatValid && beatTake;

  // Control page
  always_comb begin
    case (beatOffset)
      '0, IndStatusOffset: ctrlWord = DataWidth'(indValid);
      NumTilesOffset: ctrlWord = DataWidth'(NumTiles);
      PortalIdOffset: ctrlWord = beatSel ? DataWidth'(PortalIdHigh) : DataWidth'(PortalIdLow);
      NumPortalsOffset: ctrlWord = DataWidth'(NumPortals);
      default: ctrlWord = DataWidth'(CtrlDefaultWord);
    endcase
  end

  // User channels
  always_comb begin
    case (beatOffset)
      '0: userWord = indData;
      OffsetWidth'(4): userWord = DataWidth'(reqReady);  // Request ready level
      default: userWord = '0;
    endcase
  end

  assign readWord = beatCtrl ? ctrlWord : userWord;

  // Reading the indication word consumes it
  assign indTake = take && !beatCtrl && beatOffset == '0;

  portalFifo #(.Width(EntryWidth), .FifoDepth(FifoDepth)) readDataFifo (
    .CLK(CLK),
    .nRST(nRST),
    .enq(take),
    .din({beatLast, beatId, readWord}),
    .deq(rValid && rReady),
    .dout(dataOut),
    .full(dataFull),
    .empty(dataEmpty)
  );

  assign {rLast, rId, rData} = dataOut;
  assign rValid = !dataEmpty;

endmodule

`default_nettype wire

// File: portalTb.sv
`timescale 1ns/1ps
`default_nettype none

module portalTb;
  import portalPkg::*;

  localparam int TimeoutCycles = 80 * 50;  // About 80 beats, at most 50 cycles each

  logic CLK;
  logic nRST;
  portalAddrU arAddr = '0;
  logic [IdWidth-1:0] arId = '0;
  logic [LenWidth-1:0] arLen = '0;
  logic arValid = 1'b0;
  logic arReady;
  logic [DataWidth-1:0] rData;
  logic [IdWidth-1:0] rId;
  logic rLast;
  logic rValid;
  logic rReady = 1'b0;
  portalAddrU awAddr = '0;
  logic [IdWidth-1:0] awId = '0;
  logic [LenWidth-1:0] awLen = '0;
  logic awValid = 1'b0;
  logic awReady;
  logic [DataWidth-1:0] wData = '0;
  logic wLast = 1'b0;
  logic wValid = 1'b0;
  logic wReady;
  logic [IdWidth-1:0] bId;
  logic bValid;
  logic bReady = 1'b0;
  logic indValid = 1'b1;  // High from the start so a stray irq would show
  logic [DataWidth-1:0] indData = 32'h3C5A96E1;
  logic indTake;
  logic reqReady = 1'b1;
  logic reqValid;
  logic [DataWidth-1:0] reqData;
  logic reqLast;
  logic irq;

  logic [15:0] lfsr = 16'd4882;
  logic [DataWidth+IdWidth:0] readQ[$];  // {last, id, data}
  logic [IdWidth-1:0] respQ[$];
  logic [DataWidth:0] reqQ[$];           // {last, data}
  int cycles = 0;
  int indTakes = 0;
  int takesBefore;

  tbClock #(.HalfPeriod(5), .ResetCycles(16)) clockGen (.CLK(CLK), .nRST(nRST));

  portalTop #(.DataWidth(DataWidth), .IdWidth(IdWidth), .LenWidth(LenWidth), .FifoDepth(2)) dut (
    .*
  );

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string msg);
    reportFailure($sformatf("Mismatch at %0t: %s", $time, msg));
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic portalAddrU makeAddr(input logic sel, input logic [6:0] chan,
                                          input logic [OffsetWidth-1:0] off);
    portalAddrU a;
    a.raw = '0;
    a.fields.sel = sel;
    a.fields.chan = chan;
    a.fields.offset = off;
    return a;
  endfunction

  // Expected read word from the control page table and the user decode
  function automatic logic [DataWidth-1:0] expectedRead(input logic sel, input logic [6:0] chan,
                                                        input logic [OffsetWidth-1:0] off);
    if (chan != '0)
      return (off == 5'h00) ? indData : (off == 5'h04) ? DataWidth'(reqReady) : '0;
    if (off == 5'h00 || off == IndStatusOffset)
      return DataWidth'(indValid);
    if (off == NumTilesOffset)
      return DataWidth'(NumTiles);
    if (off == PortalIdOffset)
      return DataWidth'(sel ? PortalIdHigh : PortalIdLow);
    if (off == NumPortalsOffset)
      return DataWidth'(NumPortals);
    return CtrlDefaultWord;
  endfunction

  task automatic readBurst(input logic sel, input logic [6:0] chan,
                           input logic [OffsetWidth-1:0] off, input logic [IdWidth-1:0] id,
                           input int beats);
    logic [OffsetWidth-1:0] o;
    logic isLast;
    o = off;
    for (int i = 0; i < beats; i++) begin
      isLast = i == beats - 1;
      readQ.push_back({isLast, id, expectedRead(sel, chan, o)});
      o = o + 5'd4;  // Wraps like the bus offset
    end
    @(posedge CLK);
    arAddr <= makeAddr(sel, chan, off);
    arId <= id;
    arLen <= LenWidth'(beats - 1);
    arValid <= 1'b1;
    @(posedge CLK);
    while (!arReady) @(posedge CLK);
    arValid <= 1'b0;
  endtask

  task automatic writeBurst(input logic [6:0] chan, input logic [OffsetWidth-1:0] off,
                            input logic [IdWidth-1:0] id, input int beats,
                            input logic [DataWidth-1:0] base);
    logic isLast;
    respQ.push_back(id);
    for (int i = 0; i < beats; i++) begin
      isLast = i == beats - 1;
      if (chan != '0)
        reqQ.push_back({isLast, base + DataWidth'(i)});
    end
    @(posedge CLK);
    awAddr <= makeAddr(1'b0, chan, off);
    awId <= id;
    awLen <= LenWidth'(beats - 1);
    awValid <= 1'b1;
    @(posedge CLK);
    while (!awReady) @(posedge CLK);
    awValid <= 1'b0;
    for (int i = 0; i < beats; i++) begin
      wData <= base + DataWidth'(i);
      wLast <= i == beats - 1;
      wValid <= 1'b1;
      @(posedge CLK);
      while (!wReady) @(posedge CLK);
    end
    wValid <= 1'b0;
    wLast <= 1'b0;
  endtask

  task automatic waitIdle;
    do @(negedge CLK);
    while (readQ.size() != 0 || respQ.size() != 0 || reqQ.size() != 0);
  endtask

  always @(posedge CLK) begin : readyDriver
    logic [15:0] s1;
    logic [15:0] s2;
    s1 = lfsrNext(lfsr);
    s2 = lfsrNext(s1);
    lfsr <= s2;
    rReady <= s1[0];  // One fresh bit each
    bReady <= s2[0];
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= TimeoutCycles)
      reportFailure($sformatf("Timeout after %0d cycles with transfers outstanding", cycles));
  end

  // Scoreboard for the three outgoing streams
  always @(posedge CLK) begin
    if (nRST) begin
      if (indTake)
        indTakes++;
      if (rValid && rReady) begin
        if (readQ.size() == 0)
          reportFailure("Read data arrived with no read outstanding");
        assert ({rLast, rId, rData} == readQ[0])
          else reportMismatch($sformatf("read got %h, expected %h", {rLast, rId, rData}, readQ[0]));
        void'(readQ.pop_front());
      end
      if (bValid && bReady) begin
        if (respQ.size() == 0)
          reportFailure("Write response arrived with no write outstanding");
        assert (bId == respQ[0])
          else reportMismatch($sformatf("bId got %h, expected %h", bId, respQ[0]));
        void'(respQ.pop_front());
      end
      if (reqValid) begin
        if (reqQ.size() == 0)
          reportFailure("reqValid pulsed with no user write beat outstanding");
        assert ({reqLast, reqData} == reqQ[0])
          else reportMismatch($sformatf("request got %h, expected %h", {reqLast, reqData}, reqQ[0]));
        void'(reqQ.pop_front());
      end
    end
  end

  assert property (@(posedge CLK) !nRST |=> arReady && awReady && !rValid && !bValid
                   && !reqValid && !indTake && !irq)
    else reportMismatch("outputs not idle after reset");

  assert property (@(posedge CLK) disable iff (!nRST)
                   rValid && !rReady |=> rValid && $stable({rLast, rId, rData}))
    else reportMismatch("read data changed while stalled");

  assert property (@(posedge CLK) disable iff (!nRST) bValid && !bReady |=> bValid && $stable(bId))
    else reportMismatch("write response changed while stalled");

  assert property (@(posedge CLK) disable iff (!nRST) irq |-> indValid)
    else reportMismatch("irq high without an indication");

  initial begin
    while (!nRST) @(posedge CLK);

    // Control page reads
    readBurst(1'b0, 7'd0, NumTilesOffset, 6'd1, 1);
    readBurst(1'b0, 7'd0, PortalIdOffset, 6'd2, 1);
    readBurst(1'b1, 7'd0, PortalIdOffset, 6'd3, 1);
    readBurst(1'b0, 7'd0, NumPortalsOffset, 6'd4, 1);
    readBurst(1'b1, 7'd0, 5'h18, 6'd5, 1);
    waitIdle();

    // User burst read, indication taken once
    takesBefore = indTakes;
    readBurst(1'b0, 7'd3, 5'h00, 6'd9, 4);
    waitIdle();
    assert (indTakes - takesBefore == 1)
      else reportMismatch($sformatf("indTake pulsed %0d times", indTakes - takesBefore));

    writeBurst(7'd5, 5'h00, 6'd12, 3, 32'h7100_0000);
    waitIdle();

    // Interrupt enable on and off
    writeBurst(7'd0, IntrEnableOffset, 6'd14, 1, 32'd1);
    waitIdle();
    assert (irq) else reportMismatch("irq not raised after enable");
    @(posedge CLK);
    indValid <= 1'b0;
    @(negedge CLK);
    assert (!irq) else reportMismatch("irq stayed high after indication dropped");
    @(posedge CLK);
    indValid <= 1'b1;
    writeBurst(7'd0, IntrEnableOffset, 6'd15, 1, 32'd0);
    waitIdle();
    assert (!irq) else reportMismatch("irq still high after disable");

    // Status levels low, so their words now read back as zero
    @(posedge CLK);
    reqReady <= 1'b0;
    indValid <= 1'b0;
    @(negedge CLK);

    // Back-to-back bursts on both sides at once
    fork
      begin
        readBurst(1'b1, 7'd3, 5'h18, 6'd21, 4);
        readBurst(1'b0, 7'd0, NumTilesOffset, 6'd22, 3);
        readBurst(1'b1, 7'd9, 5'h04, 6'd23, 2);
        readBurst(1'b0, 7'd7, 5'h08, 6'd24, 5);
      end
      begin
        writeBurst(7'd4, 5'h10, 6'd31, 5, 32'h1000_0000);
        writeBurst(7'd6, 5'h08, 6'd32, 2, 32'h2000_0000);
        writeBurst(7'd0, 5'h1C, 6'd33, 2, 32'h3000_0000);
        writeBurst(7'd8, 5'h00, 6'd34, 4, 32'h4000_0000);
      end
    join
    waitIdle();

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: portalTop.sv
`timescale 1ns/1ps
`default_nettype none

module portalTop #(
  parameter int DataWidth = portalPkg::DataWidth,
  parameter int IdWidth = portalPkg::IdWidth,
  parameter int LenWidth = portalPkg::LenWidth,
  parameter int FifoDepth = 2
) (
  input  logic CLK,
  input  logic nRST,
  input  portalPkg::portalAddrU arAddr,
  input  logic [IdWidth-1:0] arId,
  input  logic [LenWidth-1:0] arLen,
  input  logic arValid,
  output logic arReady,
  output logic [DataWidth-1:0] rData,
  output logic [IdWidth-1:0] rId,
  output logic rLast,
  output logic rValid,
  input  logic rReady,
  input  portalPkg::portalAddrU awAddr,
  input  logic [IdWidth-1:0] awId,
  input  logic [LenWidth-1:0] awLen,
  input  logic awValid,
  output logic awReady,
  input  logic [DataWidth-1:0] wData,
  input  logic wLast,
  input  logic wValid,
  output logic wReady,
  output logic [IdWidth-1:0] bId,
  output logic bValid,
  input  logic bReady,
  input  logic indValid,
  input  logic [DataWidth-1:0] indData,
  output logic indTake,
  input  logic reqReady,
  output logic reqValid,
  output logic [DataWidth-1:0] reqData,
  output logic reqLast,
  output logic irq
);
  import portalPkg::*;

  logic rdBeatValid;
  logic [OffsetWidth-1:0] rdBeatOffset;
  logic [IdWidth-1:0] rdBeatId;
  logic rdBeatSel;
  logic rdBeatCtrl;
  logic rdBeatLast;
  logic rdBeatTake;

  logic wrBeatValid;
  logic [OffsetWidth-1:0] wrBeatOffset;
  logic [IdWidth-1:0] wrBeatId;
  logic wrBeatCtrl;
  logic wrBeatLast;
  logic wrBeatTake;

  burstSplitter #(.IdWidth(IdWidth), .LenWidth(LenWidth), .FifoDepth(FifoDepth)) rdSplit (
    .CLK(CLK), .nRST(nRST),
    .addr(arAddr), .id(arId), .len(arLen), .valid(arValid), .ready(arReady),
    .beatValid(rdBeatValid), .beatOffset(rdBeatOffset), .beatId(rdBeatId),
    .beatSel(rdBeatSel), .beatCtrl(rdBeatCtrl), .beatLast(rdBeatLast),
    .beatTake(rdBeatTake)
  );

  portalReadPath #(.DataWidth(DataWidth), .IdWidth(IdWidth), .FifoDepth(FifoDepth)) readPath (
    .CLK(CLK), .nRST(nRST),
    .beatValid(rdBeatValid), .beatOffset(rdBeatOffset), .beatId(rdBeatId),
    .beatSel(rdBeatSel), .beatCtrl(rdBeatCtrl), .beatLast(rdBeatLast),
    .beatTake(rdBeatTake),
    .indValid(indValid), .indData(indData), .indTake(indTake), .reqReady(reqReady),
    .rData(rData), .rId(rId), .rLast(rLast), .rValid(rValid), .rReady(rReady)
  );

  // Write portal select is not needed on the write side
  burstSplitter #(.IdWidth(IdWidth), .LenWidth(LenWidth), .FifoDepth(FifoDepth)) wrSplit (
    .CLK(CLK), .nRST(nRST),
    .addr(awAddr), .id(awId), .len(awLen), .valid(awValid), .ready(awReady),
    .beatValid(wrBeatValid), .beatOffset(wrBeatOffset), .beatId(wrBeatId),
    .beatSel(), .beatCtrl(wrBeatCtrl), .beatLast(wrBeatLast),
    .beatTake(wrBeatTake)
  );

  portalWritePath #(.DataWidth(DataWidth), .IdWidth(IdWidth), .FifoDepth(FifoDepth)) writePath (
    .CLK(CLK), .nRST(nRST),
    .addrAccept(awValid && awReady),
    .beatValid(wrBeatValid), .beatOffset(wrBeatOffset), .beatId(wrBeatId),
    .beatCtrl(wrBeatCtrl), .beatLast(wrBeatLast), .beatTake(wrBeatTake),
    .wData(wData), .wLast(wLast), .wValid(wValid), .wReady(wReady),
    .indValid(indValid), .irq(irq),
    .reqValid(reqValid), .reqData(reqData), .reqLast(reqLast),
    .bId(bId), .bValid(bValid), .bReady(bReady)
  );

endmodule

`default_nettype wire

// File: portalWritePath.sv
`timescale 1ns/1ps
`default_nettype none

module portalWritePath #(
  parameter int DataWidth = portalPkg::DataWidth,
  parameter int IdWidth = portalPkg::IdWidth,
  parameter int FifoDepth = 2
) (
  input  logic CLK,
  input  logic nRST,
  input  logic addrAccept,
  input  logic beatValid,
  input  logic [portalPkg::OffsetWidth-1:0] beatOffset,
  input  logic [IdWidth-1:0] beatId,
  input  logic beatCtrl,
  input  logic beatLast,
  output logic beatTake,
  input  logic [DataWidth-1:0] wData,
  input  logic wLast,
  input  logic wValid,
  output logic wReady,
  input  logic indValid,
  output logic irq,
  output logic reqValid,
  output logic [DataWidth-1:0] reqData,
  output logic reqLast,
  output logic [IdWidth-1:0] bId,
  output logic bValid,
  input  logic bReady
);
  import portalPkg::*;

  logic lastDataSeen;
  logic intrEnable;
  logic dataAccept;
  logic [DataWidth-1:0] dataOut;
  logic dataFull;
  logic dataEmpty;
  logic respFull;
  logic respEmpty;
  logic consume;

  // Hold off data of the next burst until its address arrives
  assign wReady = !lastDataSeen && !dataFull;
  assign dataAccept = wValid && wReady;

  portalFifo #(.Width(DataWidth), .FifoDepth(FifoDepth)) writeDataFifo (
    .CLK(CLK),
    .nRST(nRST),
    .enq(dataAccept),
    .din(wData),
    .deq(consume),
    .dout(dataOut),
    .full(dataFull),
    .empty(dataEmpty)
  );

  // Last beat also needs a free response slot
  assign beatTake = !dataEmpty && (!beatLast || !respFull);
  assign consume = beatValid && beatTake;

  assign reqValid = consume && !beatCtrl;
  assign reqData = dataOut;
  assign reqLast = beatLast;

  assign irq = intrEnable && indValid;

  portalFifo #(.Width(IdWidth), .FifoDepth(FifoDepth)) respFifo (
    .CLK(CLK),
    .nRST(nRST),
    .enq(consume && beatLast),
    .din(beatId),
    .deq(bValid && bReady),
    .dout(bId),
    .full(respFull),
    .empty(respEmpty)
  );

  assign bValid = !respEmpty;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      lastDataSeen <= 1'b0;
      intrEnable <= 1'b0;
    end else begin
      if (addrAccept)
        lastDataSeen <= 1'b0;  // New address wins
      else if (dataAccept && wLast)
        lastDataSeen <= 1'b1;
      if (consume && beatCtrl && beatOffset == IntrEnableOffset)
        intrEnable <= dataOut[0];
    end
  end

endmodule

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int HalfPeriod = 5,
  parameter int ResetCycles = 16
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #HalfPeriod CLK = ~CLK;
  end

  initial begin
    nRST <= 1'b0;
    repeat (ResetCycles) @(posedge CLK);
    nRST <= 1'b1;  // Released on an edge like any other input
  end

endmodule

`default_nettype wire
